// ==== design/pad_pkg.sv ====
/*
 * Pad counts, pad indices and JTAG tie-off constants for the pad routing,
 * plus the packed bus structs shared by the muxes and the top level
 */
package pad_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Pad counts
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_MIO = 32;
  localparam int NUM_DIO = 15;
  // Dedicated pads sit above the muxed pads in combined vectors
  localparam int NUM_IO  = NUM_MIO + NUM_DIO;

  // Muxed pad indices
  localparam int MIO_UPHY_SEL  = 2;
  localparam int MIO_JTAG_EN   = 16;
  // Boot strap, sampled by the ROM inside the core
  localparam int MIO_BOOTSTRAP = 17;
  localparam int MIO_JTAG_TRST = 18;
  localparam int MIO_JTAG_SRST = 19;

  // Dedicated pad indices
  localparam int DIO_USB_DN        = 0;
  localparam int DIO_USB_DP        = 1;
  localparam int DIO_USB_D         = 2;
  localparam int DIO_USB_SUSPEND   = 3;
  localparam int DIO_USB_TX_MODE   = 4;
  localparam int DIO_USB_DN_PULLUP = 5;
  localparam int DIO_USB_DP_PULLUP = 6;
  localparam int DIO_USB_SE0       = 7;
  localparam int DIO_USB_SENSE     = 8;
  localparam int DIO_UART_TX       = 9;
  localparam int DIO_UART_RX       = 10;
  localparam int DIO_SPI_SDO       = 11;
  localparam int DIO_SPI_SDI       = 12;
  localparam int DIO_SPI_CSB       = 13;
  localparam int DIO_SPI_SCK       = 14;

  // Same pads, indexed in the combined vector
  localparam int IO_USB_DN        = NUM_MIO + DIO_USB_DN;
  localparam int IO_USB_DP        = NUM_MIO + DIO_USB_DP;
  localparam int IO_USB_D         = NUM_MIO + DIO_USB_D;
  localparam int IO_USB_DN_PULLUP = NUM_MIO + DIO_USB_DN_PULLUP;
  localparam int IO_USB_DP_PULLUP = NUM_MIO + DIO_USB_DP_PULLUP;
  localparam int IO_USB_SENSE     = NUM_MIO + DIO_USB_SENSE;
  localparam int IO_SPI_SDO       = NUM_MIO + DIO_SPI_SDO;
  localparam int IO_SPI_SDI       = NUM_MIO + DIO_SPI_SDI;
  localparam int IO_SPI_CSB       = NUM_MIO + DIO_SPI_CSB;
  localparam int IO_SPI_SCK       = NUM_MIO + DIO_SPI_SCK;

  ////////////////////////////////////////////////////////////////////////////
  // JTAG overlay constants
  ////////////////////////////////////////////////////////////////////////////

  // Core view of taken pads, CSB idles high
  localparam logic [NUM_IO-1:0] JTAG_TIEOFF = NUM_IO'(1'b1) << IO_SPI_CSB;

  // Pads owned by JTAG while the strap is set
  localparam logic [NUM_IO-1:0] JTAG_PAD_MASK =
      (NUM_IO'(1'b1) << IO_SPI_SCK)    | (NUM_IO'(1'b1) << IO_SPI_CSB) |
      (NUM_IO'(1'b1) << IO_SPI_SDI)    | (NUM_IO'(1'b1) << IO_SPI_SDO) |
      (NUM_IO'(1'b1) << MIO_JTAG_TRST) | (NUM_IO'(1'b1) << MIO_JTAG_SRST);

  localparam int RST_SYNC_STAGES = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Bus structs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [NUM_IO-1:0] out;
    logic [NUM_IO-1:0] oe;
    logic [NUM_IO-1:0] in;
  } io_bus_t;

  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
    logic trst_n;
    logic srst_n;
  } jtag_req_t;

  // TAP held in reset, system reset released
  localparam jtag_req_t JTAG_IDLE = '{
    tck: 1'b0, tms: 1'b0, tdi: 1'b0, trst_n: 1'b0, srst_n: 1'b1
  };

  typedef struct packed {
    logic dp;
    logic dn;
    logic d;
    logic sense;
  } uphy_rx_t;

  typedef struct packed {
    logic dp;
    logic dn;
    logic oe_n;
    logic dp_pullup;
  } uphy_tx_t;

endpackage : pad_pkg

// ==== design/jtag_overlay_mux.sv ====
/*
 * Strap-selected JTAG overlay on the SPI device and two GPIO pads,
 * with tie-off of the taken pads toward the core
 */
module jtag_overlay_mux (
  // Core side, after pin-flip undo
  input  pad_pkg::io_bus_t               bus_i,
  // Pad side
  input  logic [pad_pkg::NUM_IO-1:0]     pad_in_i,
  input  logic                           jtag_tdo_i,
  output pad_pkg::io_bus_t               bus_o,
  // To the TAP and the reset generator
  output pad_pkg::jtag_req_t             jtag_o
);

  logic jtag_en;

  // Strap pad, active high
  assign jtag_en = pad_in_i[pad_pkg::MIO_JTAG_EN];

  ////////////////////////////////////////////////////////////////////////////
  // Pad direction
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    bus_o.out = bus_i.out;
    bus_o.oe  = bus_i.oe;

    if (jtag_en) begin
      // Release all taken pads first
      bus_o.out = bus_i.out & ~pad_pkg::JTAG_PAD_MASK;
      bus_o.oe  = bus_i.oe & ~pad_pkg::JTAG_PAD_MASK;

      // TDO reuses the SDO pad
      bus_o.out[pad_pkg::IO_SPI_SDO] = jtag_tdo_i;
      bus_o.oe[pad_pkg::IO_SPI_SDO]  = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Core direction
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    bus_o.in = pad_in_i;

    if (jtag_en) begin
      // Core sees a quiet SPI bus with CSB deasserted
      bus_o.in = (pad_in_i & ~pad_pkg::JTAG_PAD_MASK) |
                 (pad_pkg::JTAG_TIEOFF & pad_pkg::JTAG_PAD_MASK);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // JTAG request
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    jtag_o = pad_pkg::JTAG_IDLE;

    if (jtag_en) begin
      jtag_o.tck    = pad_in_i[pad_pkg::IO_SPI_SCK];
      jtag_o.tms    = pad_in_i[pad_pkg::IO_SPI_CSB];
      jtag_o.tdi    = pad_in_i[pad_pkg::IO_SPI_SDI];
      jtag_o.trst_n = pad_in_i[pad_pkg::MIO_JTAG_TRST];
      jtag_o.srst_n = pad_in_i[pad_pkg::MIO_JTAG_SRST];
    end
  end

endmodule : jtag_overlay_mux

// ==== design/usb_pinflip_mux.sv ====
/*
 * Undo of core USB D+/D- pin flipping, external USB PHY receive select
 * and PHY transmit outputs
 */
module usb_pinflip_mux (
  // Core side
  input  pad_pkg::io_bus_t             core_bus_i,
  output logic [pad_pkg::NUM_IO-1:0]   core_in_o,
  // Toward the JTAG stage
  input  logic [pad_pkg::NUM_IO-1:0]   bus_i,
  output pad_pkg::io_bus_t             bus_o,
  // External PHY
  input  logic                         uphy_sel_i,
  input  pad_pkg::uphy_rx_t            uphy_rx_i,
  output pad_pkg::uphy_tx_t            uphy_tx_o
);

  logic swap;
  logic rx_dp;
  logic rx_dn;
  logic rx_d;
  logic rx_sense;

  // Core signals a flip through the DN pullup enable
  assign swap = core_bus_i.oe[pad_pkg::IO_USB_DN_PULLUP];

  ////////////////////////////////////////////////////////////////////////////
  // Transmit side
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    bus_o.out = core_bus_i.out;
    bus_o.oe  = core_bus_i.oe;

    if (swap) begin
      bus_o.out[pad_pkg::IO_USB_DP] = core_bus_i.out[pad_pkg::IO_USB_DN];
      bus_o.out[pad_pkg::IO_USB_DN] = core_bus_i.out[pad_pkg::IO_USB_DP];
      bus_o.oe[pad_pkg::IO_USB_DP]  = core_bus_i.oe[pad_pkg::IO_USB_DN];
      bus_o.oe[pad_pkg::IO_USB_DN]  = core_bus_i.oe[pad_pkg::IO_USB_DP];

      bus_o.out[pad_pkg::IO_USB_DP_PULLUP] = core_bus_i.out[pad_pkg::IO_USB_DN_PULLUP];
      bus_o.out[pad_pkg::IO_USB_DN_PULLUP] = core_bus_i.out[pad_pkg::IO_USB_DP_PULLUP];
      bus_o.oe[pad_pkg::IO_USB_DP_PULLUP]  = core_bus_i.oe[pad_pkg::IO_USB_DN_PULLUP];
      bus_o.oe[pad_pkg::IO_USB_DN_PULLUP]  = core_bus_i.oe[pad_pkg::IO_USB_DP_PULLUP];

      // Differential bit flips polarity with the pins
      bus_o.out[pad_pkg::IO_USB_D] = ~core_bus_i.out[pad_pkg::IO_USB_D];
    end
  end

  // Pad receive vector handed on unchanged
  assign bus_o.in = bus_i;

  ////////////////////////////////////////////////////////////////////////////
  // Receive side
  ////////////////////////////////////////////////////////////////////////////

  // PHY select comes straight from a board switch pad
  always_comb begin
    if (uphy_sel_i) begin
      rx_dp    = uphy_rx_i.dp;
      rx_dn    = uphy_rx_i.dn;
      rx_d     = uphy_rx_i.d;
      rx_sense = uphy_rx_i.sense;
    end else begin
      rx_dp    = bus_i[pad_pkg::IO_USB_DP];
      rx_dn    = bus_i[pad_pkg::IO_USB_DN];
      rx_d     = bus_i[pad_pkg::IO_USB_D];
      rx_sense = bus_i[pad_pkg::IO_USB_SENSE];
    end
  end

  always_comb begin
    core_in_o = bus_i;
    core_in_o[pad_pkg::IO_USB_SENSE] = rx_sense;

    if (swap) begin
      core_in_o[pad_pkg::IO_USB_DP] = rx_dn;
      core_in_o[pad_pkg::IO_USB_DN] = rx_dp;
      core_in_o[pad_pkg::IO_USB_D]  = ~rx_d;
    end else begin
      core_in_o[pad_pkg::IO_USB_DP] = rx_dp;
      core_in_o[pad_pkg::IO_USB_DN] = rx_dn;
      core_in_o[pad_pkg::IO_USB_D]  = rx_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // External PHY transmit
  ////////////////////////////////////////////////////////////////////////////

  // Copies of the unflipped pad drive, PHY always listens
  always_comb begin
    uphy_tx_o.dp        = bus_o.out[pad_pkg::IO_USB_DP];
    uphy_tx_o.dn        = bus_o.out[pad_pkg::IO_USB_DN];
    uphy_tx_o.oe_n      = ~bus_o.oe[pad_pkg::IO_USB_DP];
    uphy_tx_o.dp_pullup = bus_o.out[pad_pkg::IO_USB_DP_PULLUP] &
                          bus_o.oe[pad_pkg::IO_USB_DP_PULLUP];
  end

endmodule : usb_pinflip_mux

// ==== design/core_reset_gen.sv ====
/*
 * Core reset from board reset and JTAG system reset, synchronous release
 */
module core_reset_gen (
  input  logic io_clk_i,
  input  logic rst_n_i,
  input  logic jtag_srst_n_i,
  output logic core_rst_n_o
);

  logic                                  comb_rst_n;
  logic [pad_pkg::RST_SYNC_STAGES-1:0]   sync_q;

  // Either source asserts at once
  assign comb_rst_n = rst_n_i & jtag_srst_n_i;

  // Release walks a one through the chain
  always_ff @(posedge io_clk_i or negedge comb_rst_n) begin
    if (!comb_rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[pad_pkg::RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign core_rst_n_o = sync_q[pad_pkg::RST_SYNC_STAGES-1];

endmodule : core_reset_gen

// ==== design/fpga_pad_top.sv ====
/*
 * Pad routing top: pin-flip undo, JTAG overlay and core reset generation
 */
module fpga_pad_top (
  // Board clock and reset
  input  logic                          io_clk_i,
  input  logic                          rst_n_i,
  // Core side
  input  pad_pkg::io_bus_t              core_bus_i,
  output pad_pkg::io_bus_t              core_bus_o,
  // Pad side
  input  logic [pad_pkg::NUM_IO-1:0]    pad_in_i,
  output pad_pkg::io_bus_t              pad_bus_o,
  // External USB PHY
  input  pad_pkg::uphy_rx_t             uphy_rx_i,
  output pad_pkg::uphy_tx_t             uphy_tx_o,
  // JTAG toward the TAP
  input  logic                          jtag_tdo_i,
  output pad_pkg::jtag_req_t            jtag_o,
  // Core reset
  output logic                          core_rst_n_o
);

  // Chain: core <- pin-flip mux <- JTAG mux -> pads
  pad_pkg::io_bus_t                flip_bus;
  pad_pkg::io_bus_t                jtag_bus;
  logic [pad_pkg::NUM_IO-1:0]      core_in;
  pad_pkg::jtag_req_t              jtag_req;

  ////////////////////////////////////////////////////////////////////////////
  // USB pin-flip undo
  ////////////////////////////////////////////////////////////////////////////

  usb_pinflip_mux u_usb_pinflip_mux (
    .core_bus_i ( core_bus_i                         ),
    .core_in_o  ( core_in                            ),
    .bus_i      ( jtag_bus.in                        ),
    .bus_o      ( flip_bus                           ),
    // Board switch on MIO 2 picks the external PHY
    .uphy_sel_i ( pad_in_i[pad_pkg::MIO_UPHY_SEL]    ),
    .uphy_rx_i  ( uphy_rx_i                          ),
    .uphy_tx_o  ( uphy_tx_o                          )
  );

  ////////////////////////////////////////////////////////////////////////////
  // JTAG overlay
  ////////////////////////////////////////////////////////////////////////////

  jtag_overlay_mux u_jtag_overlay_mux (
    .bus_i      ( flip_bus   ),
    .pad_in_i   ( pad_in_i   ),
    .jtag_tdo_i ( jtag_tdo_i ),
    .bus_o      ( jtag_bus   ),
    .jtag_o     ( jtag_req   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Core reset
  ////////////////////////////////////////////////////////////////////////////

  core_reset_gen u_core_reset_gen (
    .io_clk_i      ( io_clk_i        ),
    .rst_n_i       ( rst_n_i         ),
    .jtag_srst_n_i ( jtag_req.srst_n ),
    .core_rst_n_o  ( core_rst_n_o    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign jtag_o    = jtag_req;
  assign pad_bus_o = jtag_bus;

  // Core drive echoed back next to its receive vector
  assign core_bus_o.out = core_bus_i.out;
  assign core_bus_o.oe  = core_bus_i.oe;
  assign core_bus_o.in  = core_in;

endmodule : fpga_pad_top

// ==== testbench/pad_checker.sv ====
/*
 * Reference model of the pad routing rules, compared against the DUT
 * one cycle after each stimulus row, with per-test and summary lines
 */
module pad_checker (
  input  logic                         clk_i,
  // DUT ports, observed only
  input  pad_pkg::io_bus_t             core_drive_i,
  input  pad_pkg::io_bus_t             core_ret_i,
  input  logic [pad_pkg::NUM_IO-1:0]   pad_in_i,
  input  pad_pkg::io_bus_t             pad_drive_i,
  input  pad_pkg::uphy_rx_t            uphy_rx_i,
  input  pad_pkg::uphy_tx_t            uphy_tx_i,
  input  logic                         jtag_tdo_i,
  input  pad_pkg::jtag_req_t           jtag_req_i,
  input  logic                         core_rst_n_i,
  // From the stimulus loop
  input  logic                         check_i,
  input  logic                         report_i,
  input  int                           row_id_i,
  input  logic                         exp_rst_n_i,
  output int                           pass_cnt_o,
  output int                           fail_cnt_o
);

  localparam int W = pad_pkg::NUM_IO;

  // Pads that go to JTAG input or are released, SDO handled apart
  localparam int TAKEN [5] = '{
    pad_pkg::IO_SPI_SCK, pad_pkg::IO_SPI_CSB, pad_pkg::IO_SPI_SDI,
    pad_pkg::MIO_JTAG_TRST, pad_pkg::MIO_JTAG_SRST
  };

  int    pass_cnt = 0;
  int    fail_cnt = 0;
  int    row_bad;
  string row_msg;
  // Reset output seen before the first clock edge of a row
  logic  early_rst_n;

  assign pass_cnt_o = pass_cnt;
  assign fail_cnt_o = fail_cnt;

  function automatic logic [W-1:0] exchange(input logic [W-1:0] v, input int a, input int b);
    logic [W-1:0] r;
    r    = v;
    r[a] = v[b];
    r[b] = v[a];
    return r;
  endfunction

  // Keeps the first mismatch of a row for its report line
  task automatic compare_field(input string what, input logic [W-1:0] exp_v,
                               input logic [W-1:0] got_v);
    if (got_v !== exp_v) begin
      if (row_bad == 0) begin
        row_msg = $sformatf("%s expected %h got %h", what, exp_v, got_v);
      end
      row_bad++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Expected values from the routing rules
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_row();
    logic [W-1:0]       flip_out;
    logic [W-1:0]       flip_oe;
    logic [W-1:0]       exp_out;
    logic [W-1:0]       exp_oe;
    logic [W-1:0]       jtag_in;
    logic [W-1:0]       exp_core_in;
    pad_pkg::jtag_req_t exp_jtag;
    pad_pkg::uphy_tx_t  exp_tx;
    logic               sw;
    logic               sel;
    logic               jen;
    logic               rx_dp;
    logic               rx_dn;
    logic               rx_d;
    logic               rx_sense;

    sw  = core_drive_i.oe[pad_pkg::IO_USB_DN_PULLUP];
    sel = pad_in_i[pad_pkg::MIO_UPHY_SEL];
    jen = pad_in_i[pad_pkg::MIO_JTAG_EN];
    row_bad = 0;
    row_msg = "";

    // Core drive after the pin-flip undo
    flip_out = core_drive_i.out;
    flip_oe  = core_drive_i.oe;
    if (sw) begin
      flip_out = exchange(flip_out, pad_pkg::IO_USB_DP, pad_pkg::IO_USB_DN);
      flip_oe  = exchange(flip_oe, pad_pkg::IO_USB_DP, pad_pkg::IO_USB_DN);
      flip_out = exchange(flip_out, pad_pkg::IO_USB_DP_PULLUP, pad_pkg::IO_USB_DN_PULLUP);
      flip_oe  = exchange(flip_oe, pad_pkg::IO_USB_DP_PULLUP, pad_pkg::IO_USB_DN_PULLUP);
      flip_out[pad_pkg::IO_USB_D] = ~flip_out[pad_pkg::IO_USB_D];
    end

    // JTAG takeover of pads
    exp_out = flip_out;
    exp_oe  = flip_oe;
    jtag_in = pad_in_i;
    if (jen) begin
      for (int k = 0; k < 5; k++) begin
        exp_out[TAKEN[k]] = 1'b0;
        exp_oe[TAKEN[k]]  = 1'b0;
        jtag_in[TAKEN[k]] = 1'b0;
      end
      exp_out[pad_pkg::IO_SPI_SDO] = jtag_tdo_i;
      exp_oe[pad_pkg::IO_SPI_SDO]  = 1'b1;
      jtag_in[pad_pkg::IO_SPI_SDO] = 1'b0;
      jtag_in[pad_pkg::IO_SPI_CSB] = 1'b1;
    end

    // Receive side, PHY select then swap
    if (sel) begin
      {rx_dp, rx_dn, rx_d, rx_sense} = {uphy_rx_i.dp, uphy_rx_i.dn, uphy_rx_i.d, uphy_rx_i.sense};
    end else begin
      rx_dp    = jtag_in[pad_pkg::IO_USB_DP];
      rx_dn    = jtag_in[pad_pkg::IO_USB_DN];
      rx_d     = jtag_in[pad_pkg::IO_USB_D];
      rx_sense = jtag_in[pad_pkg::IO_USB_SENSE];
    end
    exp_core_in = jtag_in;
    exp_core_in[pad_pkg::IO_USB_SENSE] = rx_sense;
    exp_core_in[pad_pkg::IO_USB_DP]    = sw ? rx_dn : rx_dp;
    exp_core_in[pad_pkg::IO_USB_DN]    = sw ? rx_dp : rx_dn;
    exp_core_in[pad_pkg::IO_USB_D]     = rx_d ^ sw;

    exp_jtag.tck    = jen & pad_in_i[pad_pkg::IO_SPI_SCK];
    exp_jtag.tms    = jen & pad_in_i[pad_pkg::IO_SPI_CSB];
    exp_jtag.tdi    = jen & pad_in_i[pad_pkg::IO_SPI_SDI];
    exp_jtag.trst_n = jen & pad_in_i[pad_pkg::MIO_JTAG_TRST];
    exp_jtag.srst_n = jen ? pad_in_i[pad_pkg::MIO_JTAG_SRST] : 1'b1;

    exp_tx.dp        = flip_out[pad_pkg::IO_USB_DP];
    exp_tx.dn        = flip_out[pad_pkg::IO_USB_DN];
    exp_tx.oe_n      = ~flip_oe[pad_pkg::IO_USB_DP];
    exp_tx.dp_pullup = flip_out[pad_pkg::IO_USB_DP_PULLUP] & flip_oe[pad_pkg::IO_USB_DP_PULLUP];

    compare_field("pad out", exp_out, pad_drive_i.out);
    compare_field("pad oe", exp_oe, pad_drive_i.oe);
    compare_field("pad in", jtag_in, pad_drive_i.in);
    compare_field("core in", exp_core_in, core_ret_i.in);
    compare_field("core out echo", core_drive_i.out, core_ret_i.out);
    compare_field("core oe echo", core_drive_i.oe, core_ret_i.oe);
    compare_field("jtag request", W'(exp_jtag), W'(jtag_req_i));
    compare_field("uphy tx", W'(exp_tx), W'(uphy_tx_i));
    compare_field("core reset", W'(exp_rst_n_i), W'(core_rst_n_i));

    // An active reset source pulls the output low without a clock edge
    if (exp_rst_n_i == 1'b0) begin
      compare_field("core reset at once", W'(1'b0), W'(early_rst_n));
    end

    if (row_bad == 0) begin
      pass_cnt++;
      $display("PASS test %0d", row_id_i);
    end else begin
      fail_cnt++;
      $display("FAIL t=%0t test %0d: %s (%0d fields wrong)", $time, row_id_i, row_msg, row_bad);
    end
  endtask

  // Inputs change just after the rising edge, so the falling edge is quiet
  always @(negedge clk_i) begin
    if (check_i) begin
      check_row();
    end else begin
      early_rst_n = core_rst_n_i;
    end
    if (report_i) begin
      $display("Tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    end
  end

endmodule : pad_checker

// ==== testbench/tb_top.sv ====
/*
 * Testbench for the pad routing top: clock, reset, stimulus table
 * applied in a loop, cycle timeout and the final verdict
 */
module tb_top;

  typedef struct packed {
    logic jtag_en;
    logic swap;
    logic uphy_sel;
    logic srst_n;
    logic board_rst_n;
    logic tdo;
    logic exp_rst_n;
  } row_t;

  localparam int NUM_ROWS       = 20;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 4 + 40;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table, other pad and core bits are random per row
  ////////////////////////////////////////////////////////////////////////////

  localparam row_t ROWS [NUM_ROWS] = '{
    // jtag_en swap  uphy_sel srst_n board_rst_n tdo exp_rst_n
    '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1},  // 0 straight through
    '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1},  // 1
    '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1},  // 2 JTAG takeover
    '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1},  // 3 JTAG plus flip
    '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1},  // 4 pin flip
    '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1},  // 5
    '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1},  // 6 PHY select, no flip
    '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1},  // 7 PHY select with flip
    '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},  // 8 everything on
    '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},  // 9 SRST pad low
    '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0},  // 10 first edge after release
    '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1},  // 11 released
    '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},  // 12 board reset
    '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0},  // 13
    '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},  // 14
    '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1},  // 15 SRST ignored, JTAG off
    '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0},  // 16
    '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0},  // 17
    '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},  // 18
    '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1}   // 19
  };

  logic                        clk;
  logic                        rst_n;
  pad_pkg::io_bus_t            core_bus;
  pad_pkg::io_bus_t            core_ret;
  logic [pad_pkg::NUM_IO-1:0]  pad_in;
  pad_pkg::io_bus_t            pad_bus;
  pad_pkg::uphy_rx_t           uphy_rx;
  pad_pkg::uphy_tx_t           uphy_tx;
  logic                        tdo;
  pad_pkg::jtag_req_t          jtag_req;
  logic                        core_rst_n;
  logic                        check;
  logic                        report;
  int                          row_id;
  logic                        exp_rst_n;
  int                          pass_cnt;
  int                          fail_cnt;
  int                          cycle_cnt = 0;
  int unsigned                 seed_val;

  always #2 clk = ~clk;

  fpga_pad_top DUT (
    .io_clk_i     ( clk        ),
    .rst_n_i      ( rst_n      ),
    .core_bus_i   ( core_bus   ),
    .core_bus_o   ( core_ret   ),
    .pad_in_i     ( pad_in     ),
    .pad_bus_o    ( pad_bus    ),
    .uphy_rx_i    ( uphy_rx    ),
    .uphy_tx_o    ( uphy_tx    ),
    .jtag_tdo_i   ( tdo        ),
    .jtag_o       ( jtag_req   ),
    .core_rst_n_o ( core_rst_n )
  );

  pad_checker u_pad_checker (
    .clk_i        ( clk        ),
    .core_drive_i ( core_bus   ),
    .core_ret_i   ( core_ret   ),
    .pad_in_i     ( pad_in     ),
    .pad_drive_i  ( pad_bus    ),
    .uphy_rx_i    ( uphy_rx    ),
    .uphy_tx_i    ( uphy_tx    ),
    .jtag_tdo_i   ( tdo        ),
    .jtag_req_i   ( jtag_req   ),
    .core_rst_n_i ( core_rst_n ),
    .check_i      ( check      ),
    .report_i     ( report     ),
    .row_id_i     ( row_id     ),
    .exp_rst_n_i  ( exp_rst_n  ),
    .pass_cnt_o   ( pass_cnt   ),
    .fail_cnt_o   ( fail_cnt   )
  );

  // Random fill first, then the row's control bits on top
  task automatic apply_row(input int idx);
    logic [63:0] rnd;
    row_t        r;
    r   = ROWS[idx];
    rnd = {$urandom, $urandom};
    core_bus.out = rnd[pad_pkg::NUM_IO-1:0];
    rnd = {$urandom, $urandom};
    core_bus.oe = rnd[pad_pkg::NUM_IO-1:0];
    core_bus.oe[pad_pkg::IO_USB_DN_PULLUP] = r.swap;
    rnd = {$urandom, $urandom};
    pad_in = rnd[pad_pkg::NUM_IO-1:0];
    pad_in[pad_pkg::MIO_JTAG_EN]   = r.jtag_en;
    pad_in[pad_pkg::MIO_UPHY_SEL]  = r.uphy_sel;
    pad_in[pad_pkg::MIO_JTAG_SRST] = r.srst_n;
    rnd = {$urandom, $urandom};
    uphy_rx   = rnd[3:0];
    tdo       = r.tdo;
    rst_n     = r.board_rst_n;
    exp_rst_n = r.exp_rst_n;
    row_id    = idx;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    core_bus  = '0;
    pad_in    = '0;
    uphy_rx   = '0;
    tdo       = 1'b0;
    check     = 1'b0;
    report    = 1'b0;
    row_id    = 0;
    exp_rst_n = 1'b0;
    seed_val  = $urandom(32'h9805);

    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;

    // Each row holds two cycles and is checked on the second one
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk);
      #1;
      apply_row(i);
      check = 1'b0;
      @(posedge clk);
      #1 check = 1'b1;
    end

    @(posedge clk);
    #1;
    check  = 1'b0;
    report = 1'b1;
    @(negedge clk);
    #1;
    if (fail_cnt == 0 && pass_cnt == NUM_ROWS) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

endmodule : tb_top

// ==== flist.f ====
design/pad_pkg.sv
design/jtag_overlay_mux.sv
design/usb_pinflip_mux.sv
design/core_reset_gen.sv
design/fpga_pad_top.sv
testbench/pad_checker.sv
testbench/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -j 0 \
  --top-module tb_top \
  -Mdir "$BUILD_DIR" -o tb_top \
  -f flist.f

"./$BUILD_DIR/tb_top" | tee "$LOG_FILE"

if grep -q "Simulation finished: PASS" "$LOG_FILE"; then
  echo "Run passed, log in $LOG_FILE"
else
  echo "Run failed, see $LOG_FILE"
  exit 1
fi
